// File: hdl/thread_pkg.sv
// thread fetch package
// program-counter type, in-flight fetch record and restart handshake states

package thread_pkg;

    // --------------------
    // program counter
    // --------------------

    // width of every program counter in the store
    localparam int PC_WIDTH = 10;

    typedef logic [PC_WIDTH-1:0] pc_t;

    // --------------------
    // fetch pipeline
    // --------------------

    // one fetch travelling from store read to writeback
    typedef struct packed {
        logic valid;
        pc_t  pc;
    } fetch_stage_t;

    // --------------------
    // restart handshake
    // --------------------

    // idle -> pending until the store takes it -> acked until req drops
    typedef enum logic [1:0] {
        CFG_IDLE    = 2'd0,
        CFG_PENDING = 2'd1,
        CFG_ACKED   = 2'd2
    } cfg_state_t;

endpackage

// File: hdl/pc_ctl_if.sv
// restart control link
// carries one pending thread restart from the config block to the sequencer

`timescale 1ns/1ps

interface pc_ctl_if
    import thread_pkg::*;
#(
    parameter int THREAD_ADDR_WIDTH = 3
);

    // command held by the config block while pending
    logic                         restart_pending;
    logic [THREAD_ADDR_WIDTH-1:0] restart_thread;
    pc_t                          restart_pc;
    logic                         restart_enable;

    // one-cycle pulse from the sequencer when the store takes it
    logic                         restart_done;

    // config side drives the command
    modport cfg (
        output restart_pending,
        output restart_thread,
        output restart_pc,
        output restart_enable,
        input  restart_done
    );

    // sequencer side consumes it at the writeback slot
    modport seq (
        input  restart_pending,
        input  restart_thread,
        input  restart_pc,
        input  restart_enable,
        output restart_done
    );

endinterface

// File: hdl/thread_number.sv
// round-robin thread counter
// steps one thread per cycle, wraps at THREAD_COUNT, restarts at INITIAL_THREAD

`timescale 1ns/1ps

module thread_number #(
    parameter int INITIAL_THREAD    = 0,
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3
) (
    input  logic                         clock,
    input  logic                         rst,
    output logic [THREAD_ADDR_WIDTH-1:0] current_thread,
    output logic [THREAD_ADDR_WIDTH-1:0] next_thread
);

    // reset value and wrap point
    localparam logic [THREAD_ADDR_WIDTH-1:0] START_THREAD = THREAD_ADDR_WIDTH'(INITIAL_THREAD);
    localparam logic [THREAD_ADDR_WIDTH-1:0] LAST_THREAD  = THREAD_ADDR_WIDTH'(THREAD_COUNT - 1);

    // --------------------
    // successor
    // --------------------

    // wraps back to thread 0 after the last one
    always_comb begin
        if (current_thread == LAST_THREAD) begin
            next_thread = '0;
        end else begin
            next_thread = current_thread + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            current_thread <= START_THREAD;
        end else begin
            current_thread <= next_thread;
        end
    end

    // counter never leaves the valid thread range
    a_thread_in_range : assert property (
        @(posedge clock) disable iff (rst)
        current_thread < THREAD_COUNT
    );

endmodule

// File: hdl/branching_thread_number.sv
// read and write thread generator
// write thread trails the read thread by FETCH_DELAY, using an offset counter

`timescale 1ns/1ps

module branching_thread_number #(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3,
    parameter int FETCH_DELAY       = 3
) (
    input  logic                         clock,
    input  logic                         rst,
    output logic [THREAD_ADDR_WIDTH-1:0] read_thread,
    output logic [THREAD_ADDR_WIDTH-1:0] write_thread
);

    // write counter starts FETCH_DELAY threads behind thread 0
    localparam int WRITE_START = (THREAD_COUNT - FETCH_DELAY) % THREAD_COUNT;

    // --------------------
    // read side
    // --------------------

    thread_number #(
        .INITIAL_THREAD    (0),
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH)
    ) i_read_number (
        .clock          (clock),
        .rst            (rst),
        .current_thread (read_thread),
        .next_thread    ()
    );

    // --------------------
    // write side
    // --------------------

    // same counter with an offset start stands in for a preloaded delay line
    thread_number #(
        .INITIAL_THREAD    (WRITE_START),
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH)
    ) i_write_number (
        .clock          (clock),
        .rst            (rst),
        .current_thread (write_thread),
        .next_thread    ()
    );

    // both counters must stay locked FETCH_DELAY apart
    a_delay_locked : assert property (
        @(posedge clock) disable iff (rst)
        ((int'(read_thread) + THREAD_COUNT - int'(write_thread)) % THREAD_COUNT) == FETCH_DELAY
    );

endmodule

// File: hdl/pc_config.sv
// restart command register block
// takes thread restarts over a four-phase req/ack port and holds them
// pending until the sequencer writes them into the pc store

`timescale 1ns/1ps

module pc_config
    import thread_pkg::*;
#(
    parameter int THREAD_ADDR_WIDTH = 3
) (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         cfg_req,
    input  logic [THREAD_ADDR_WIDTH-1:0] cfg_thread,
    input  pc_t                          cfg_pc,
    input  logic                         cfg_enable,
    output logic                         cfg_ack,
    pc_ctl_if.cfg                        ctl
);

    cfg_state_t                   state;
    logic                         req_q;
    logic                         req_rise;

    // latched command
    logic [THREAD_ADDR_WIDTH-1:0] cmd_thread;
    pc_t                          cmd_pc;
    logic                         cmd_enable;

    // new command only on a fresh rising edge
    assign req_rise = cfg_req && !req_q;

    // --------------------
    // handshake FSM
    // --------------------

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= CFG_IDLE;
            req_q <= 1'b0;
        end else begin
            req_q <= cfg_req;
            case (state)
                CFG_IDLE: begin
                    if (req_rise) begin
                        state <= CFG_PENDING;
                    end
                end
                // wait for the thread's writeback slot
                CFG_PENDING: begin
                    if (ctl.restart_done) begin
                        state <= CFG_ACKED;
                    end
                end
                // hold ack until the requester lets go
                CFG_ACKED: begin
                    if (!cfg_req) begin
                        state <= CFG_IDLE;
                    end
                end
                default: state <= CFG_IDLE;
            endcase
        end
    end

    // payload latched from a new command
    always_ff @(posedge clock) begin
        if (state == CFG_IDLE && req_rise) begin
            cmd_thread <= cfg_thread;
            cmd_pc     <= cfg_pc;
            cmd_enable <= cfg_enable;
        end
    end

    // --------------------
    // outputs
    // --------------------

    assign cfg_ack             = (state == CFG_ACKED);
    assign ctl.restart_pending = (state == CFG_PENDING);
    assign ctl.restart_thread  = cmd_thread;
    assign ctl.restart_pc      = cmd_pc;
    assign ctl.restart_enable  = cmd_enable;

    // ack only answers a request held at the edge that raised it
    a_ack_needs_req : assert property (
        @(posedge clock) disable iff (rst)
        $rose(cfg_ack) |-> $past(cfg_req)
    );

endmodule

// File: hdl/pc_sequencer.sv
// per-thread program-counter sequencer
// reads a thread's pc each cycle, carries it FETCH_DELAY stages, then
// writes back the branch target, the increment or a pending restart

`timescale 1ns/1ps

module pc_sequencer
    import thread_pkg::*;
#(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3,
    parameter int FETCH_DELAY       = 3
) (
    input  logic                         clock,
    input  logic                         rst,
    input  logic [THREAD_ADDR_WIDTH-1:0] read_thread,
    input  logic [THREAD_ADDR_WIDTH-1:0] write_thread,
    input  logic                         branch_taken,
    input  pc_t                          branch_target,
    output logic                         fetch_valid,
    output logic [THREAD_ADDR_WIDTH-1:0] fetch_thread,
    output pc_t                          fetch_pc,
    pc_ctl_if.seq                        ctl
);

    // per-thread state
    pc_t          pc_mem     [THREAD_COUNT];
    logic         enable_mem [THREAD_COUNT];

    // in-flight fetches with the oldest at the end
    fetch_stage_t stage      [FETCH_DELAY];
    fetch_stage_t read_stage;

    logic         restart_hit;
    pc_t          wb_pc;
    logic         wb_write;

    // --------------------
    // store read
    // --------------------

    // enable bit as it stands at the read decides validity
    always_comb begin
        read_stage.valid = enable_mem[read_thread];
        read_stage.pc    = pc_mem[read_thread];
    end

    // --------------------
    // fetch pipeline
    // --------------------

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < FETCH_DELAY; i++) begin
                stage[i].valid <= 1'b0;
            end
        end else begin
            stage[0] <= read_stage;
            for (int i = 1; i < FETCH_DELAY; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // write thread lines up with the oldest stage
    assign fetch_valid  = stage[FETCH_DELAY-1].valid;
    assign fetch_pc     = stage[FETCH_DELAY-1].pc;
    assign fetch_thread = write_thread;

    // --------------------
    // writeback
    // --------------------

    // restart wins over branch/increment in its thread's slot
    assign restart_hit = ctl.restart_pending && (ctl.restart_thread == write_thread);

    always_comb begin
        if (restart_hit) begin
            wb_pc = ctl.restart_pc;
        end else if (branch_taken) begin
            wb_pc = branch_target;
        end else begin
            // wraps at the top of the pc range
            wb_pc = fetch_pc + 1'b1;
        end
    end

    // disabled thread keeps its pc unless restarted
    assign wb_write = restart_hit || fetch_valid;

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                pc_mem[t]     <= '0;
                enable_mem[t] <= 1'b1;
            end
        end else begin
            if (wb_write) begin
                pc_mem[write_thread] <= wb_pc;
            end
            if (restart_hit) begin
                enable_mem[write_thread] <= ctl.restart_enable;
            end
        end
    end

    // single pulse back to the config block
    assign ctl.restart_done = restart_hit;

endmodule

// File: hdl/thread_fetch_top.sv
// thread fetch front end
// round-robin thread generator, restart config block and pc sequencer

`timescale 1ns/1ps

module thread_fetch_top
    import thread_pkg::*;
#(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3,
    parameter int FETCH_DELAY       = 3
) (
    input  logic                         clock,
    input  logic                         rst,
    // restart command port
    input  logic                         cfg_req,
    input  logic [THREAD_ADDR_WIDTH-1:0] cfg_thread,
    input  pc_t                          cfg_pc,
    input  logic                         cfg_enable,
    output logic                         cfg_ack,
    // branch result for the thread on the fetch outputs
    input  logic                         branch_taken,
    input  pc_t                          branch_target,
    // fetch outputs
    output logic                         fetch_valid,
    output logic [THREAD_ADDR_WIDTH-1:0] fetch_thread,
    output pc_t                          fetch_pc
);

    logic [THREAD_ADDR_WIDTH-1:0] read_thread;
    logic [THREAD_ADDR_WIDTH-1:0] write_thread;

    pc_ctl_if #(.THREAD_ADDR_WIDTH(THREAD_ADDR_WIDTH)) i_pc_ctl ();

    // --------------------
    // thread slots
    // --------------------

    branching_thread_number #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .FETCH_DELAY       (FETCH_DELAY)
    ) i_branching_thread_number (
        .clock        (clock),
        .rst          (rst),
        .read_thread  (read_thread),
        .write_thread (write_thread)
    );

    // --------------------
    // restart config
    // --------------------

    pc_config #(
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH)
    ) i_pc_config (
        .clock      (clock),
        .rst        (rst),
        .cfg_req    (cfg_req),
        .cfg_thread (cfg_thread),
        .cfg_pc     (cfg_pc),
        .cfg_enable (cfg_enable),
        .cfg_ack    (cfg_ack),
        .ctl        (i_pc_ctl.cfg)
    );

    // --------------------
    // pc store and pipeline
    // --------------------

    pc_sequencer #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .FETCH_DELAY       (FETCH_DELAY)
    ) i_pc_sequencer (
        .clock         (clock),
        .rst           (rst),
        .read_thread   (read_thread),
        .write_thread  (write_thread),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .fetch_valid   (fetch_valid),
        .fetch_thread  (fetch_thread),
        .fetch_pc      (fetch_pc),
        .ctl           (i_pc_ctl.seq)
    );

endmodule

// File: verif/fetch_checker.sv
// fetch output checker
// keeps a per-thread pc and enable model, compares every fetch slot
// and watches the restart req/ack handshake

`timescale 1ns/1ps

module fetch_checker
    import thread_pkg::*;
#(
    parameter int THREAD_COUNT      = 8,
    parameter int THREAD_ADDR_WIDTH = 3,
    parameter int FETCH_DELAY       = 3
) (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         cfg_req,
    input  logic [THREAD_ADDR_WIDTH-1:0] cfg_thread,
    input  pc_t                          cfg_pc,
    input  logic                         cfg_enable,
    input  logic                         cfg_ack,
    input  logic                         branch_taken,
    input  pc_t                          branch_target,
    input  logic                         fetch_valid,
    input  logic [THREAD_ADDR_WIDTH-1:0] fetch_thread,
    input  pc_t                          fetch_pc,
    output int                           error_count
);

    // ack must come within a full thread round plus two
    localparam int ACK_RISE_LIMIT = THREAD_COUNT + 2;
    localparam int ACK_FALL_LIMIT = 2;

    // model of the pc store
    pc_t   model_pc [THREAD_COUNT];
    logic  model_en [THREAD_COUNT];
    string pc_rule  [THREAD_COUNT];

    int    exp_thread;
    int    cycle;
    logic  req_q;
    logic  ack_q;
    int    ack_wait;
    int    drop_wait;

    // restart seen on the command port
    int    cmd_thread;
    pc_t   cmd_pc;
    logic  cmd_enable;

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("ERR %s: expected %0d actual %0d at %0t", name, expected, actual, $time);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        error_count++;
    endtask

    // sampled mid-cycle away from the drive edge
    always @(negedge clock) begin
        if (rst) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                model_pc[t] = '0;
                model_en[t] = 1'b1;
                pc_rule[t]  = "reset_pc";
            end
            // write slot already sits FETCH_DELAY behind thread 0
            exp_thread = (THREAD_COUNT - FETCH_DELAY) % THREAD_COUNT;
            cycle      = 0;
            req_q      = 1'b0;
            ack_q      = 1'b0;
            ack_wait   = 0;
            drop_wait  = 0;
        end else begin
            // --------------------
            // handshake
            // --------------------
            if (cfg_req && !req_q && !cfg_ack) begin
                cmd_thread = int'(cfg_thread);
                cmd_pc     = cfg_pc;
                cmd_enable = cfg_enable;
            end
            // requester may already have let go in the cycle ack rose
            if (cfg_ack && !ack_q && !req_q) begin
                report_failure("handshake: cfg_ack rose while cfg_req was low");
            end
            if (cfg_req && !cfg_ack) begin
                ack_wait++;
                if (ack_wait == ACK_RISE_LIMIT + 1) begin
                    report_failure("handshake: cfg_ack did not rise in time after cfg_req");
                end
            end else begin
                ack_wait = 0;
            end
            if (!cfg_req && cfg_ack) begin
                drop_wait++;
                if (drop_wait == ACK_FALL_LIMIT + 1) begin
                    report_failure("handshake: cfg_ack stayed high after cfg_req fell");
                end
            end else begin
                drop_wait = 0;
            end

            // --------------------
            // fetch slot
            // --------------------
            if (int'(fetch_thread) != exp_thread) begin
                report_mismatch("order", exp_thread, int'(fetch_thread));
            end
            if (cycle < FETCH_DELAY) begin
                // pipeline still filling
                if (fetch_valid !== 1'b0) begin
                    report_mismatch("reset_valid", 0, int'(fetch_valid));
                end
                if (cfg_ack !== 1'b0) begin
                    report_failure("reset: cfg_ack high while the fetch pipeline was filling");
                end
                cycle++;
            end else begin
                if (fetch_valid !== model_en[exp_thread]) begin
                    report_mismatch("valid", int'(model_en[exp_thread]), int'(fetch_valid));
                end
                if (fetch_pc !== model_pc[exp_thread]) begin
                    report_mismatch(pc_rule[exp_thread], int'(model_pc[exp_thread]),
                                    int'(fetch_pc));
                end
                // disabled thread holds its pc
                if (model_en[exp_thread]) begin
                    if (branch_taken) begin
                        model_pc[exp_thread] = branch_target;
                        pc_rule[exp_thread]  = "branch";
                    end else begin
                        model_pc[exp_thread] = model_pc[exp_thread] + 1'b1;
                        pc_rule[exp_thread]  = "flow";
                    end
                end
            end
            exp_thread = (exp_thread + 1) % THREAD_COUNT;

            // restart has landed in the store by the time ack rises
            if (cfg_ack && !ack_q) begin
                model_pc[cmd_thread] = cmd_pc;
                model_en[cmd_thread] = cmd_enable;
                pc_rule[cmd_thread]  = "restart";
            end
            req_q = cfg_req;
            ack_q = cfg_ack;
        end
    end

endmodule

// File: verif/tb_thread_fetch.sv
// thread fetch testbench
// random branches every cycle, a restart over req/ack every round, watchdog

`timescale 1ns/1ps

module tb_thread_fetch
    import thread_pkg::*;
();

    localparam int THREAD_COUNT      = 8;
    localparam int THREAD_ADDR_WIDTH = 3;
    localparam int FETCH_DELAY       = 3;
    localparam int HALF_PERIOD       = 4;
    localparam int ROUNDS            = 12;
    localparam int ROUND_CYCLES      = 40;
    localparam int MARGIN_CYCLES     = 200;
    localparam int LEAD_CYCLES       = 16;
    localparam int WATCHDOG_CYCLES   = ROUNDS * ROUND_CYCLES + MARGIN_CYCLES;
    // driver side limits looser than the checker's
    localparam int ACK_LIMIT         = THREAD_COUNT + 4;
    localparam int DROP_LIMIT        = 4;

    logic                         clock;
    logic                         rst;
    logic                         cfg_req;
    logic [THREAD_ADDR_WIDTH-1:0] cfg_thread;
    pc_t                          cfg_pc;
    logic                         cfg_enable;
    logic                         cfg_ack;
    logic                         branch_taken;
    pc_t                          branch_target;
    logic                         fetch_valid;
    logic [THREAD_ADDR_WIDTH-1:0] fetch_thread;
    pc_t                          fetch_pc;

    logic [31:0]                  rng_state;
    int                           cycle_count;
    int                           stim_errors;
    int                           checker_errors;

    thread_fetch_top #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .FETCH_DELAY       (FETCH_DELAY)
    ) i_thread_fetch_top (
        .clock         (clock),
        .rst           (rst),
        .cfg_req       (cfg_req),
        .cfg_thread    (cfg_thread),
        .cfg_pc        (cfg_pc),
        .cfg_enable    (cfg_enable),
        .cfg_ack       (cfg_ack),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .fetch_valid   (fetch_valid),
        .fetch_thread  (fetch_thread),
        .fetch_pc      (fetch_pc)
    );

    fetch_checker #(
        .THREAD_COUNT      (THREAD_COUNT),
        .THREAD_ADDR_WIDTH (THREAD_ADDR_WIDTH),
        .FETCH_DELAY       (FETCH_DELAY)
    ) i_fetch_checker (
        .clock         (clock),
        .rst           (rst),
        .cfg_req       (cfg_req),
        .cfg_thread    (cfg_thread),
        .cfg_pc        (cfg_pc),
        .cfg_enable    (cfg_enable),
        .cfg_ack       (cfg_ack),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .fetch_valid   (fetch_valid),
        .fetch_thread  (fetch_thread),
        .fetch_pc      (fetch_pc),
        .error_count   (checker_errors)
    );

    // --------------------
    // stimulus helpers
    // --------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // fresh branch result 1 ns after each clock
    task automatic next_cycle();
        @(posedge clock);
        #1;
        rng_state     = xorshift32(rng_state);
        branch_taken  = (rng_state[3:2] == 2'b00);
        branch_target = pc_t'(rng_state[25:16]);
        cycle_count++;
    endtask

    // four-phase restart with bounded waits
    task automatic send_restart();
        int waited;
        rng_state  = xorshift32(rng_state);
        cfg_thread = THREAD_ADDR_WIDTH'(rng_state % THREAD_COUNT);
        cfg_pc     = pc_t'(rng_state[19:10]);
        cfg_enable = (rng_state[31:30] != 2'b00);
        cfg_req    = 1'b1;
        waited     = 0;
        while (!cfg_ack && waited < ACK_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!cfg_ack) begin
            $display("restart: no cfg_ack after %0d cycles at %0t", waited, $time);
            stim_errors++;
        end
        cfg_req = 1'b0;
        waited  = 0;
        while (cfg_ack && waited < DROP_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (cfg_ack) begin
            $display("restart: cfg_ack still high after cfg_req fell at %0t", $time);
            stim_errors++;
        end
    endtask

    // --------------------
    // clock and watchdog
    // --------------------

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    // --------------------
    // main sequence
    // --------------------

    initial begin
        int round_start;
        int total;
        rst           = 1'b1;
        cfg_req       = 1'b0;
        cfg_thread    = '0;
        cfg_pc        = '0;
        cfg_enable    = 1'b0;
        branch_taken  = 1'b0;
        branch_target = '0;
        rng_state     = 32'd83;
        cycle_count   = 0;
        stim_errors   = 0;
        assert (FETCH_DELAY < THREAD_COUNT) else begin
            $display("parameter check: FETCH_DELAY must be below THREAD_COUNT");
            stim_errors++;
        end
        assert ((1 << THREAD_ADDR_WIDTH) >= THREAD_COUNT) else begin
            $display("parameter check: THREAD_ADDR_WIDTH too narrow for THREAD_COUNT");
            stim_errors++;
        end
        repeat (2) @(posedge clock);
        #1;
        rst = 1'b0;
        // first pass of every thread runs from pc 0
        repeat (LEAD_CYCLES) next_cycle();
        for (int r = 0; r < ROUNDS; r++) begin
            round_start = cycle_count;
            send_restart();
            while (cycle_count - round_start < ROUND_CYCLES) begin
                next_cycle();
            end
        end
        total = checker_errors + stim_errors;
        $display("error counts: checker %0d, stimulus %0d", checker_errors, stim_errors);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/thread_pkg.sv
hdl/pc_ctl_if.sv
hdl/thread_number.sv
hdl/branching_thread_number.sv
hdl/pc_config.sv
hdl/pc_sequencer.sv
hdl/thread_fetch_top.sv
verif/fetch_checker.sv
verif/tb_thread_fetch.sv

// File: run_sim.sh
#!/bin/sh
# build and run the thread fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -sv -f sources.f \
    --top-module tb_thread_fetch -Mdir obj_dir -o tb_thread_fetch
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_thread_fetch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
